// File: verilog/hist_pkg.sv
package hist_pkg;

  // Stream sample width.
  localparam int sample_width = 16;

  // Bin select bits taken from the bottom of each sample.
  localparam int bin_addr_width = 6;

  // One RAM entry per bin.
  localparam int bin_count = 2 ** bin_addr_width;

  // Width of one bin count; counts stop at the all-ones value.
  localparam int count_width = 8;

  // Host commands.
  typedef enum logic [0:0]
  {
    CMD_READ  = 1'b0,
    CMD_CLEAR = 1'b1
  } hist_cmd_e;

endpackage

// File: verilog/bram_port_if.sv
`timescale 1ns/1ns

interface bram_port_if;
  import hist_pkg::*;

  logic                      en;
  logic                      we;
  logic [bin_addr_width-1:0] addr;
  logic [count_width-1:0]    wdata;
  logic [count_width-1:0]    rdata;

  // Side that issues reads and writes.
  modport master
  (
    output en,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  // RAM side.
  modport slave
  (
    input  en,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: verilog/axis_histogram.sv
`timescale 1ns/1ns

module axis_histogram
(
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic [hist_pkg::sample_width-1:0] s_axis_tdata,
  input  logic                              s_axis_tvalid,
  output logic                              s_axis_tready,
  input  logic                              hold,
  bram_port_if.master                       bram
);
  import hist_pkg::*;

  typedef enum logic [1:0]
  {
    idle,
    fetch,
    store
  } state_e;

  state_e                    state;
  logic                      tready_reg;
  logic                      we_reg;
  logic [bin_addr_width-1:0] addr_reg;
  logic [count_width-1:0]    data_reg;
  logic                      transfer;

  // The readout owns the RAM while a clear is running.
  assign s_axis_tready = tready_reg & ~hold;
  assign transfer = s_axis_tvalid & s_axis_tready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state <= idle;
      tready_reg <= 1'b1;
      we_reg <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (transfer)
          begin
            tready_reg <= 1'b0;
            state <= fetch;
          end
        end
        fetch:
        begin
          // A full bin is left alone.
          we_reg <= ~&bram.rdata;
          state <= store;
        end
        store:
        begin
          we_reg <= 1'b0;
          tready_reg <= 1'b1;
          state <= idle;
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (transfer)
    begin
      addr_reg <= s_axis_tdata[bin_addr_width-1:0];
    end
    if (state == fetch)
    begin
      data_reg <= bram.rdata + count_width'(1);
    end
  end

  // Read in the transfer cycle, write two cycles later.
  assign bram.en = transfer | we_reg;
  assign bram.we = we_reg;
  assign bram.addr = we_reg ? addr_reg : s_axis_tdata[bin_addr_width-1:0];
  assign bram.wdata = data_reg;

endmodule

// File: verilog/hist_bram.sv
`timescale 1ns/1ns

module hist_bram
(
  input  logic       aclk,
  bram_port_if.slave port_a,
  bram_port_if.slave port_b
);
  import hist_pkg::*;

  logic [count_width-1:0] mem [bin_count];

  // Both ports are read-first.
  // The design never writes one address from both ports in the same cycle.
  always_ff @(posedge aclk)
  begin
    if (port_a.en)
    begin
      if (port_a.we)
      begin
        mem[port_a.addr] <= port_a.wdata;
      end
      port_a.rdata <= mem[port_a.addr];
    end

    if (port_b.en)
    begin
      if (port_b.we)
      begin
        mem[port_b.addr] <= port_b.wdata;
      end
      port_b.rdata <= mem[port_b.addr];
    end
  end

endmodule

// File: verilog/hist_readout.sv
`timescale 1ns/1ns

module hist_readout
(
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic                                cmd_valid,
  input  hist_pkg::hist_cmd_e                 cmd_op,
  input  logic [hist_pkg::bin_addr_width-1:0] cmd_addr,
  output logic                                cmd_ready,
  output logic                                rsp_valid,
  output logic [hist_pkg::count_width-1:0]    rsp_data,
  output logic                                hold,
  bram_port_if.master                         bram
);
  import hist_pkg::*;

  typedef enum logic [2:0]
  {
    idle,
    read_addr,
    read_data,
    drain,
    sweep
  } state_e;

  state_e                    state;
  logic [bin_addr_width-1:0] addr_reg;
  logic                      drain_cnt;
  logic                      accept;
  logic                      last_bin;

  assign accept = cmd_valid & cmd_ready;
  assign last_bin = (addr_reg == bin_addr_width'(bin_count - 1));

  // Also serves as the sweep index during a clear.
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state <= idle;
      addr_reg <= '0;
      drain_cnt <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (accept)
          begin
            drain_cnt <= 1'b0;
            if (cmd_op == CMD_CLEAR)
            begin
              addr_reg <= '0;
              state <= drain;
            end
            else
            begin
              addr_reg <= cmd_addr;
              state <= read_addr;
            end
          end
        end
        read_addr:
        begin
          state <= read_data;
        end
        read_data:
        begin
          state <= idle;
        end
        drain:
        begin
          // Two cycles let a pending increment land.
          drain_cnt <= 1'b1;
          if (drain_cnt)
          begin
            state <= sweep;
          end
        end
        sweep:
        begin
          addr_reg <= addr_reg + 1'b1;
          if (last_bin)
          begin
            state <= idle;
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  assign cmd_ready = (state == idle);
  assign hold = (state == drain) || (state == sweep);

  // RAM data is valid the cycle after the address.
  assign rsp_valid = (state == read_data);
  assign rsp_data = bram.rdata;

  assign bram.en = (state == read_addr) || (state == sweep);
  assign bram.we = (state == sweep);
  assign bram.addr = addr_reg;
  assign bram.wdata = '0;

endmodule

// File: verilog/hist_top.sv
`timescale 1ns/1ns

module hist_top
(
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic [hist_pkg::sample_width-1:0]   s_axis_tdata,
  input  logic                                s_axis_tvalid,
  output logic                                s_axis_tready,
  input  logic                                cmd_valid,
  input  hist_pkg::hist_cmd_e                 cmd_op,
  input  logic [hist_pkg::bin_addr_width-1:0] cmd_addr,
  output logic                                cmd_ready,
  output logic                                rsp_valid,
  output logic [hist_pkg::count_width-1:0]    rsp_data
);

  logic hold;

  // Port a for the host, port b for the stream.
  bram_port_if port_a ();
  bram_port_if port_b ();

  axis_histogram i_axis_histogram
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .hold          (hold),
    .bram          (port_b)
  );

  hist_readout i_hist_readout
  (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .hold      (hold),
    .bram      (port_a)
  );

  hist_bram i_hist_bram
  (
    .aclk   (aclk),
    .port_a (port_a),
    .port_b (port_b)
  );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
(
  output logic aclk,
  output logic aresetn
);

  localparam int half_period = 2;
  localparam int reset_cycles = 8;

  initial
  begin
    aclk = 1'b0;
    forever #half_period aclk = ~aclk;
  end

  // Released on a rising edge after the reset cycles.
  initial
  begin
    aresetn = 1'b0;
    repeat (reset_cycles) @(posedge aclk);
    aresetn <= 1'b1;
  end

endmodule

// File: sim/hist_tb.sv
`timescale 1ns/1ns

module hist_tb;
  import hist_pkg::*;

  localparam int clk_period = 4;
  localparam int num_steps = 10;
  localparam int step_cycles = 1000;
  localparam int timeout_ns = (num_steps * step_cycles + 20) * clk_period;

  typedef enum logic [2:0]
  {
    burst,
    saturate,
    clear_all,
    clear_streaming,
    read_back
  } kind_e;

  // Value is the bin for a saturating burst and the delay before a clear
  // that overlaps the stream.
  typedef struct packed
  {
    kind_e       kind;
    logic [15:0] value;
    logic [15:0] count;
    logic [15:0] expected;
  } step_t;

  logic                      aclk;
  logic                      aresetn;
  logic [sample_width-1:0]   s_axis_tdata;
  logic                      s_axis_tvalid;
  logic                      s_axis_tready;
  logic                      cmd_valid;
  hist_cmd_e                 cmd_op;
  logic [bin_addr_width-1:0] cmd_addr;
  logic                      cmd_ready;
  logic                      rsp_valid;
  logic [count_width-1:0]    rsp_data;

  step_t                     steps [num_steps];
  logic [count_width-1:0]    model [bin_count];
  logic [15:0]               lfsr_state;
  int                        cyc = 0;
  int                        xfer_count = 0;
  int                        last_xfer = 0;
  logic                      clearing = 1'b0;

  tb_clock i_tb_clock
  (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  hist_top i_hist_top
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_addr      (cmd_addr),
    .cmd_ready     (cmd_ready),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // Galois form, taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0])
    begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  function automatic logic [15:0] next_bits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val = {val[14:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return val;
  endfunction

  always @(posedge aclk)
  begin
    cyc <= cyc + 1;
  end

  // Reference model and stream checks, sampled mid-cycle.
  always @(negedge aclk)
  begin
    int gap;
    logic [bin_addr_width-1:0] bin;
    if (aresetn)
    begin
      if (s_axis_tvalid && s_axis_tready)
      begin
        gap = cyc - last_xfer;
        if (xfer_count > 0)
        begin
          check_value("transfer_gap", (gap > 3) ? 32'd3 : 32'(gap), 32'd3);
        end
        last_xfer = cyc;
        xfer_count = xfer_count + 1;
        bin = s_axis_tdata[bin_addr_width-1:0];
        if (model[bin] != {count_width{1'b1}})
        begin
          model[bin] = model[bin] + 1'b1;
        end
      end
      // An increment accepted in the same cycle is wiped by the sweep.
      if (cmd_valid && cmd_ready && cmd_op == CMD_CLEAR)
      begin
        foreach (model[k])
        begin
          model[k] = '0;
        end
        clearing = 1'b1;
      end
      else if (clearing && cmd_ready)
      begin
        clearing = 1'b0;
      end
      if (clearing && !cmd_ready)
      begin
        check_value("s_axis_tready", 32'(s_axis_tready), 32'd0);
      end
    end
  end

  // Holds tvalid high across samples, then waits for the engine to go idle.
  task automatic send_samples(input int n, input logic fixed_bin,
                              input logic [bin_addr_width-1:0] bin);
    logic [15:0] sample;
    logic [15:0] high;
    for (int i = 0; i < n; i++)
    begin
      if (fixed_bin)
      begin
        high = next_bits(10);
        sample = {high[9:0], bin};
      end
      else
      begin
        sample = next_bits(16);
      end
      s_axis_tdata <= sample;
      s_axis_tvalid <= 1'b1;
      do @(negedge aclk); while (!s_axis_tready);
      @(posedge aclk);
    end
    s_axis_tvalid <= 1'b0;
    do @(negedge aclk); while (!s_axis_tready);
    @(posedge aclk);
  endtask

  task automatic read_bin(input logic [bin_addr_width-1:0] addr,
                          output logic [count_width-1:0] data);
    int acc;
    int rsp_cyc;
    cmd_valid <= 1'b1;
    cmd_op <= CMD_READ;
    cmd_addr <= addr;
    do @(negedge aclk); while (!cmd_ready);
    acc = cyc;
    @(posedge aclk);
    cmd_valid <= 1'b0;
    do @(negedge aclk); while (!rsp_valid);
    rsp_cyc = cyc;
    data = rsp_data;
    check_value("rsp_valid_latency", 32'(rsp_cyc - acc), 32'd2);
    @(negedge aclk);
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    @(posedge aclk);
  endtask

  task automatic clear_bins(input int ready_latency);
    int acc;
    cmd_valid <= 1'b1;
    cmd_op <= CMD_CLEAR;
    cmd_addr <= '0;
    do @(negedge aclk); while (!cmd_ready);
    acc = cyc;
    @(posedge aclk);
    cmd_valid <= 1'b0;
    do
    begin
      @(negedge aclk);
      check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    end
    while (!cmd_ready);
    check_value("clear_latency", 32'(cyc - acc), 32'(ready_latency));
    @(posedge aclk);
  endtask

  task automatic read_all_bins();
    logic [count_width-1:0] data;
    for (int b = 0; b < bin_count; b++)
    begin
      read_bin(bin_addr_width'(b), data);
      check_value($sformatf("rsp_data bin %0d", b), 32'(data), 32'(model[b]));
    end
  endtask

  initial
  begin
    #(timeout_ns);
    $display("Timeout: the histogram tests did not finish in %0d ns.", timeout_ns);
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial
  begin
    logic [bin_addr_width-1:0] bin;
    logic [count_width-1:0]    data;
    logic [count_width-1:0]    left_before;
    logic [count_width-1:0]    right_before;
    s_axis_tdata = '0;
    s_axis_tvalid = 1'b0;
    cmd_valid = 1'b0;
    cmd_op = CMD_READ;
    cmd_addr = '0;
    lfsr_state = 16'd31;
    foreach (model[k])
    begin
      model[k] = '0;
    end
    steps = '{
      '{clear_all,       16'd0,  16'd0,   16'd67},
      '{read_back,       16'd0,  16'd0,   16'd0},
      '{burst,           16'd0,  16'd200, 16'd0},
      '{read_back,       16'd0,  16'd0,   16'd0},
      '{saturate,        16'd37, 16'd260, 16'd255},
      '{read_back,       16'd0,  16'd0,   16'd0},
      '{clear_streaming, 16'd5,  16'd40,  16'd67},
      '{read_back,       16'd0,  16'd0,   16'd0},
      '{burst,           16'd0,  16'd120, 16'd0},
      '{read_back,       16'd0,  16'd0,   16'd0}
    };

    do @(negedge aclk); while (!aresetn);
    check_value("s_axis_tready", 32'(s_axis_tready), 32'd1);
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    @(posedge aclk);

    for (int i = 0; i < num_steps; i++)
    begin
      case (steps[i].kind)
        burst:
        begin
          send_samples(int'(steps[i].count), 1'b0, '0);
        end
        saturate:
        begin
          bin = steps[i].value[bin_addr_width-1:0];
          left_before = model[bin - 6'd1];
          right_before = model[bin + 6'd1];
          send_samples(int'(steps[i].count), 1'b1, bin);
          read_bin(bin, data);
          check_value("rsp_data saturated", 32'(data), 32'(steps[i].expected));
          read_bin(bin - 6'd1, data);
          check_value("rsp_data below", 32'(data), 32'(left_before));
          read_bin(bin + 6'd1, data);
          check_value("rsp_data above", 32'(data), 32'(right_before));
        end
        clear_all:
        begin
          clear_bins(int'(steps[i].expected));
        end
        clear_streaming:
        begin
          fork
            send_samples(int'(steps[i].count), 1'b0, '0);
            begin
              repeat (int'(steps[i].value)) @(posedge aclk);
              clear_bins(int'(steps[i].expected));
            end
          join
        end
        read_back:
        begin
          read_all_bins();
        end
        default:
        begin
          $display("Step %0d has an unknown kind.", i);
          $display("TESTS FAILED");
          $fatal(1);
        end
      endcase
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: all.f
verilog/hist_pkg.sv
verilog/bram_port_if.sv
verilog/axis_histogram.sv
verilog/hist_bram.sv
verilog/hist_readout.sv
verilog/hist_top.sv
sim/tb_clock.sv
sim/hist_tb.sv

// File: run.sh
#!/bin/sh
# Builds the histogram testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module hist_tb --Mdir obj_dir -o hist_sim

# The simulator exits non-zero on a failed check, so its status is not used here.
output=$(./obj_dir/hist_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"
then
  exit 0
fi
exit 1
